/* bench/plb_master_tasks.svh */
`ifndef PLB_MASTER_TASKS_SVH
`define PLB_MASTER_TASKS_SVH

// Address phase in cycle T, returns in the middle of T+1
task automatic send_request(input logic rnw, input logic [31:0] addr, input logic [7:0] be,
                            input logic [3:0] size, input logic [63:0] first_beat,
                            input bit want_ack);
   @(posedge plb_clk);
   pa_valid <= 1'b1;
   req      <= '{addr: addr, rnw: rnw, be: be, size: size};
   wr_dbus  <= first_beat;
   @(negedge plb_clk);
   assert (!addr_ack) else report_fail("addr_ack in the request cycle");
   @(posedge plb_clk);
   pa_valid <= 1'b0;
   req      <= '0;
   @(negedge plb_clk);
   assert (addr_ack == want_ack)
      else report_fail($sformatf("addr_ack %b in T+1 for address %h", addr_ack, addr));
endtask

task automatic write_transfer(input logic [31:0] addr, input bit line, input logic [7:0] be,
                              input logic [3:0][63:0] data);
   int          n;
   logic [31:0] base;
   n    = line ? 4 : 1;
   base = line ? {addr[31:5], 5'd0} : {addr[31:3], 3'd0};
   for (int k = 0; k < n; k++) begin
      void'(expect_word(1'b1, base + 32'(8 * k), line ? 8'hFF : be, data[k]));
   end
   send_request(1'b0, base, line ? 8'hFF : be, line ? SIZE_LINE : SIZE_SINGLE, data[0], 1'b1);
   for (int k = 0; k < n; k++) begin
      if (k > 0) @(negedge plb_clk);
      assert (wr_dack && (wr_comp == (k == n - 1)) && (addr_ack == (k == 0)))
         else report_fail($sformatf("write beat %0d: wr_dack %b wr_comp %b addr_ack %b",
                                    k, wr_dack, wr_comp, addr_ack));
      // Next doubleword goes out after each wr_dack
      @(posedge plb_clk);
      if (k < n - 1) wr_dbus <= data[k + 1];
   end
   @(negedge plb_clk);
   assert (!wr_dack && !wr_comp) else report_fail("wr_dack or wr_comp past the last beat");
endtask

task automatic read_transfer(input logic [31:0] addr, input bit line);
   int          n;
   int          waited;
   logic [31:0] base;
   beat_exp_t   e;
   n    = line ? 4 : 1;
   base = line ? {addr[31:5], 5'd0} : {addr[31:3], 3'd0};
   for (int k = 0; k < n; k++) begin
      e.data = expect_word(1'b0, base + 32'(8 * k), 8'h00, 64'd0);
      e.idx  = 2'(k);
      e.comp = (k == n - 1);
      exp_q.push_back(e);
   end
   send_request(1'b1, base, 8'hFF, line ? SIZE_LINE : SIZE_SINGLE, 64'd0, 1'b1);
   waited = 0;
   while (!(rd_dack && rd_comp)) begin
      waited++;
      assert (waited < 20)
         else abort_run($sformatf("Read of %h did not complete within 20 cycles", base));
      @(negedge plb_clk);
   end
endtask

task automatic reject_request(input logic rnw, input logic [31:0] addr, input logic [3:0] size);
   send_request(rnw, addr, 8'hFF, size, 64'hDEAD_BEEF_0BAD_F00D, 1'b0);
   repeat (9) begin
      @(negedge plb_clk);
      assert (!addr_ack && !wr_dack && !rd_dack)
         else report_fail($sformatf("response to rejected request at %h", addr));
   end
endtask

`endif

/* bench/plb_ddr2_tb.sv */
`timescale 1ns/1ps

module plb_ddr2_tb;

   import plb_ddr2_pkg::*;

   localparam int          CLK_PERIOD      = 20;
   localparam logic [31:0] SEED            = 32'h26b2f15e;
   localparam int          SINGLE_PAIRS    = 16;
   localparam int          LINE_PAIRS      = 4;
   localparam int          RANDOM_XFERS    = 200;
   // Four rejects and three confirming reads
   localparam int          PLANNED_XFERS   = 2 * SINGLE_PAIRS + 2 * LINE_PAIRS + 7 + RANDOM_XFERS;
   localparam int          WATCHDOG_CYCLES = 40 * PLANNED_XFERS + 100;

   typedef struct packed {
      logic [63:0] data;
      logic [1:0]  idx;
      logic        comp;
   } beat_exp_t;

   logic        plb_clk;
   logic        rst;
   logic        pa_valid;
   plb_req_t    req;
   logic [63:0] wr_dbus;
   logic        addr_ack;
   logic        wr_dack;
   logic        wr_comp;
   logic [63:0] rd_dbus;
   logic [1:0]  rd_wd_addr;
   logic        rd_dack;
   logic        rd_comp;

   logic [7:0]  shadow [MEM_LINES * LINE_BYTES];
   beat_exp_t   exp_q [$];
   int          error_count;

   plb_ddr2 dut_i (
      .plb_clk    (plb_clk),
      .rst        (rst),
      .pa_valid   (pa_valid),
      .req        (req),
      .wr_dbus    (wr_dbus),
      .addr_ack   (addr_ack),
      .wr_dack    (wr_dack),
      .wr_comp    (wr_comp),
      .rd_dbus    (rd_dbus),
      .rd_wd_addr (rd_wd_addr),
      .rd_dack    (rd_dack),
      .rd_comp    (rd_comp)
   );

   initial begin
      plb_clk = 1'b0;
      forever #(CLK_PERIOD / 2) plb_clk = ~plb_clk;
   end

   //----------------------------------------------------------------------
   // Shadow memory model and error reporting
   //----------------------------------------------------------------------

   // Byte lane i is bits 8i+7..8i, window starts at address 0
   function automatic logic [63:0] expect_word(input logic wr, input logic [31:0] addr,
                                               input logic [7:0] be, input logic [63:0] data);
      logic [63:0] word;
      int          base;
      base = int'(addr[11:3]) * 8;
      for (int i = 0; i < 8; i++) begin
         if (wr && be[i]) shadow[base + i] = data[8*i +: 8];
         word[8*i +: 8] = shadow[base + i];
      end
      return word;
   endfunction

   function automatic logic [255:0] random_data();
      logic [255:0] r;
      for (int i = 0; i < 8; i++) r[32*i +: 32] = $urandom;
      return r;
   endfunction

   task automatic report_fail(input string msg);
      error_count++;
      $display("Fail at %0t ns: %s", $time, msg);
      $display("FAIL: see errors above");
      $fatal(1, "stopping at first error");
   endtask

   task automatic abort_run(input string msg);
      error_count++;
      $display("%s", msg);
      $display("FAIL: see errors above");
      $fatal(1, "run aborted");
   endtask

   `include "plb_master_tasks.svh"

   // Every read beat against the queued expectation
   always @(negedge plb_clk) begin : beat_checker
      beat_exp_t e;
      if (!rst) begin
         assert (rd_dack || !rd_comp) else report_fail("rd_comp without rd_dack");
         if (rd_dack) begin
            assert (exp_q.size() > 0) else abort_run("rd_dack with no read outstanding");
            e = exp_q.pop_front();
            assert (rd_dbus == e.data)
               else report_fail($sformatf("rd_dbus %h, expected %h", rd_dbus, e.data));
            assert (rd_wd_addr == e.idx)
               else report_fail($sformatf("rd_wd_addr %0d, expected %0d", rd_wd_addr, e.idx));
            assert (rd_comp == e.comp)
               else report_fail($sformatf("rd_comp %b on beat %0d", rd_comp, e.idx));
         end
      end
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      abort_run("Watchdog expired, the run hung");
   end

   //----------------------------------------------------------------------
   // Test sequences
   //----------------------------------------------------------------------

   task automatic idle_after_reset();
      repeat (8) begin
         @(negedge plb_clk);
         assert (!addr_ack && !wr_dack && !wr_comp && !rd_dack && !rd_comp &&
                 !dut_i.mem_cmd.rd && !dut_i.mem_cmd.wr)
            else report_fail("strobe high while idle after reset");
      end
   endtask

   task automatic single_word_rw();
      logic [31:0] addrs [SINGLE_PAIRS];
      for (int i = 0; i < SINGLE_PAIRS; i++) begin
         addrs[i] = $urandom & 32'h0000_0FF8;
         write_transfer(addrs[i], 1'b0, 8'($urandom), random_data());
      end
      for (int i = 0; i < SINGLE_PAIRS; i++) read_transfer(addrs[i], 1'b0);
   endtask

   task automatic line_rw();
      logic [31:0] addrs [LINE_PAIRS];
      addrs = '{32'h000, 32'h040, 32'h080, 32'hFE0};
      for (int i = 0; i < LINE_PAIRS; i++) write_transfer(addrs[i], 1'b1, 8'hFF, random_data());
      for (int i = 0; i < LINE_PAIRS; i++) read_transfer(addrs[i], 1'b1);
   endtask

   task automatic rejected_requests();
      // Decoded by offset alone these would land on lines already written
      reject_request(1'b0, 32'h0000_1040, SIZE_SINGLE);
      reject_request(1'b0, 32'h0000_0080, 4'd2);
      reject_request(1'b0, 32'h2000_0000, SIZE_LINE);
      reject_request(1'b1, 32'h0000_0100, 4'd3);
      read_transfer(32'h0000_0040, 1'b0);
      read_transfer(32'h0000_0080, 1'b0);
      read_transfer(32'h0000_0000, 1'b1);
   endtask

   task automatic random_mix();
      int          kind;
      logic [31:0] addr;
      for (int i = 0; i < RANDOM_XFERS; i++) begin
         kind = $urandom % 4;
         addr = $urandom & 32'h0000_0FF8;
         case (kind)
            0:       write_transfer(addr, 1'b0, 8'($urandom), random_data());
            1:       read_transfer(addr, 1'b0);
            2:       write_transfer(addr, 1'b1, 8'hFF, random_data());
            default: read_transfer(addr, 1'b1);
         endcase
      end
   endtask

   initial begin
      void'($urandom(SEED));
      error_count = 0;
      rst         = 1'b1;
      pa_valid    = 1'b0;
      req         = '0;
      wr_dbus     = '0;
      for (int i = 0; i < MEM_LINES * LINE_BYTES; i++) shadow[i] = 8'h00;
      repeat (3) @(posedge plb_clk);
      rst <= 1'b0;
      idle_after_reset();
      single_word_rw();
      line_rw();
      rejected_requests();
      random_mix();
      repeat (2) @(posedge plb_clk);
      if (error_count == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

/* compile.f */
+incdir+bench
hdl/plb_ddr2_pkg.sv
hdl/beat_counter.sv
hdl/line_buffer.sv
hdl/ddr_line_store.sv
hdl/plb_slave_fsm.sv
hdl/plb_ddr2.sv
bench/plb_ddr2_tb.sv

/* hdl/beat_counter.sv */
`timescale 1ns/1ps

module beat_counter (
   input  logic       plb_clk,
   input  logic       rst,
   input  logic       clear,
   input  logic       advance,
   output logic [1:0] beat,
   output logic       last,
   output logic       line_done
);

   //----------------------------------------------------------------------
   // Doubleword beat count within the open transfer
   //----------------------------------------------------------------------

   always_ff @(posedge plb_clk) begin
      if (rst) begin
         beat <= 2'd0;
      end else if (clear) begin
         beat <= 2'd0;
      end else if (advance) begin
         beat <= beat + 2'd1;
      end
   end

   // Fourth doubleword of a line
   assign last      = (beat == 2'd3);

   // Odd beats close a 128-bit memory line
   assign line_done = beat[0];

endmodule

/* hdl/ddr_line_store.sv */
`timescale 1ns/1ps

module ddr_line_store (
   input  logic                      plb_clk,
   input  logic                      rst,
   input  plb_ddr2_pkg::ddr_cmd_t    cmd,
   output logic                      rd_valid,
   output plb_ddr2_pkg::mem_line_u   rdata
);

   import plb_ddr2_pkg::*;

   mem_line_u               mem [MEM_LINES];
   mem_line_u               rd_pipe [READ_LATENCY];
   logic [READ_LATENCY-1:0] vld_pipe;

   // Memory starts out cleared
   initial begin
      for (int i = 0; i < MEM_LINES; i++) begin
         mem[i] = '0;
      end
   end

   //----------------------------------------------------------------------
   // Byte-enabled line write
   //----------------------------------------------------------------------

   always_ff @(posedge plb_clk) begin
      if (cmd.wr) begin
         for (int b = 0; b < LINE_BYTES; b++) begin
            if (cmd.be[b]) begin
               mem[cmd.line_addr].raw[8*b +: 8] <= cmd.wdata.raw[8*b +: 8];
            end
         end
      end
   end

   //----------------------------------------------------------------------
   // Read pipeline, more than one read may be in flight
   //----------------------------------------------------------------------

   always_ff @(posedge plb_clk) begin
      rd_pipe[0] <= mem[cmd.line_addr];
      for (int s = 1; s < READ_LATENCY; s++) begin
         rd_pipe[s] <= rd_pipe[s-1];
      end
   end

   always_ff @(posedge plb_clk) begin
      if (rst) begin
         vld_pipe <= '0;
      end else begin
         vld_pipe <= {vld_pipe[READ_LATENCY-2:0], cmd.rd};
      end
   end

   assign rd_valid = vld_pipe[READ_LATENCY-1];
   assign rdata    = rd_pipe[READ_LATENCY-1];

endmodule

/* hdl/line_buffer.sv */
`timescale 1ns/1ps

module line_buffer (
   input  logic                                  plb_clk,
   input  logic                                  rst,
   input  logic                                  wr_capture,
   input  logic                                  single,
   input  logic                                  addr_bit3,
   input  logic [plb_ddr2_pkg::DWORD_BYTES-1:0]  byte_en,
   input  logic [plb_ddr2_pkg::DWORD_W-1:0]      wr_dbus,
   input  logic [1:0]                            beat,
   input  logic                                  rd_select,
   input  logic                                  rd_valid,
   input  plb_ddr2_pkg::mem_line_u               rdata,
   output plb_ddr2_pkg::mem_line_u               wdata,
   output logic [plb_ddr2_pkg::LINE_BYTES-1:0]   line_be,
   output logic [plb_ddr2_pkg::DWORD_W-1:0]      rd_dbus
);

   import plb_ddr2_pkg::*;

   logic      slot;
   mem_line_u rd_line;

   // Doubleword slot within the line
   assign slot = single ? addr_bit3 : beat[0];

   //----------------------------------------------------------------------
   // Write side
   //----------------------------------------------------------------------

   always_ff @(posedge plb_clk) begin
      if (wr_capture) begin
         wdata.dword[slot] <= wr_dbus;
      end
   end

   always_ff @(posedge plb_clk) begin
      if (rst) begin
         line_be <= '0;
      end else if (wr_capture) begin
         if (single) begin
            // Only the addressed doubleword is written
            if (addr_bit3) begin
               line_be <= {byte_en, {DWORD_BYTES{1'b0}}};
            end else begin
               line_be <= {{DWORD_BYTES{1'b0}}, byte_en};
            end
         end else begin
            line_be[DWORD_BYTES*slot +: DWORD_BYTES] <= '1;
         end
      end
   end

   //----------------------------------------------------------------------
   // Read side
   //----------------------------------------------------------------------

   always_ff @(posedge plb_clk) begin
      if (rd_valid) begin
         rd_line <= rdata;
      end
   end

   // Bus is quiet outside read beats
   assign rd_dbus = rd_select ? rd_line.dword[slot] : '0;

endmodule

/* hdl/plb_ddr2.sv */
`timescale 1ns/1ps

module plb_ddr2 (
   input  logic                                 plb_clk,
   input  logic                                 rst,
   input  logic                                 pa_valid,
   input  plb_ddr2_pkg::plb_req_t               req,
   input  logic [plb_ddr2_pkg::DWORD_W-1:0]     wr_dbus,
   output logic                                 addr_ack,
   output logic                                 wr_dack,
   output logic                                 wr_comp,
   output logic [plb_ddr2_pkg::DWORD_W-1:0]     rd_dbus,
   output logic [1:0]                           rd_wd_addr,
   output logic                                 rd_dack,
   output logic                                 rd_comp
);

   import plb_ddr2_pkg::*;

   //----------------------------------------------------------------------
   // Internal wiring
   //----------------------------------------------------------------------

   logic                   cnt_clear;
   logic                   cnt_advance;
   logic [1:0]             beat;
   logic                   last;
   logic                   line_done;

   logic                   wr_capture;
   logic                   rd_select;
   logic                   single;
   logic                   addr_bit3;
   logic [DWORD_BYTES-1:0] byte_en;

   logic                   cmd_rd;
   logic                   cmd_wr;
   logic [LINE_AW-1:0]     line_addr;
   logic [LINE_BYTES-1:0]  line_be;
   mem_line_u              wdata;
   ddr_cmd_t               mem_cmd;

   logic                   rd_valid;
   mem_line_u              rdata;

   // Memory command bundle
   assign mem_cmd.rd        = cmd_rd;
   assign mem_cmd.wr        = cmd_wr;
   assign mem_cmd.line_addr = line_addr;
   assign mem_cmd.be        = line_be;
   assign mem_cmd.wdata     = wdata;

   //----------------------------------------------------------------------
   // Instances
   //----------------------------------------------------------------------

   plb_slave_fsm fsm_i (
      .plb_clk     (plb_clk),
      .rst         (rst),
      .pa_valid    (pa_valid),
      .req         (req),
      .beat        (beat),
      .last        (last),
      .line_done   (line_done),
      .rd_valid    (rd_valid),
      .cnt_clear   (cnt_clear),
      .cnt_advance (cnt_advance),
      .wr_capture  (wr_capture),
      .rd_select   (rd_select),
      .single      (single),
      .addr_bit3   (addr_bit3),
      .byte_en     (byte_en),
      .cmd_rd      (cmd_rd),
      .cmd_wr      (cmd_wr),
      .line_addr   (line_addr),
      .addr_ack    (addr_ack),
      .wr_dack     (wr_dack),
      .wr_comp     (wr_comp),
      .rd_dack     (rd_dack),
      .rd_comp     (rd_comp),
      .rd_wd_addr  (rd_wd_addr)
   );

   beat_counter beat_cnt_i (
      .plb_clk   (plb_clk),
      .rst       (rst),
      .clear     (cnt_clear),
      .advance   (cnt_advance),
      .beat      (beat),
      .last      (last),
      .line_done (line_done)
   );

   line_buffer line_buf_i (
      .plb_clk    (plb_clk),
      .rst        (rst),
      .wr_capture (wr_capture),
      .single     (single),
      .addr_bit3  (addr_bit3),
      .byte_en    (byte_en),
      .wr_dbus    (wr_dbus),
      .beat       (beat),
      .rd_select  (rd_select),
      .rd_valid   (rd_valid),
      .rdata      (rdata),
      .wdata      (wdata),
      .line_be    (line_be),
      .rd_dbus    (rd_dbus)
   );

   ddr_line_store store_i (
      .plb_clk  (plb_clk),
      .rst      (rst),
      .cmd      (mem_cmd),
      .rd_valid (rd_valid),
      .rdata    (rdata)
   );

endmodule

/* hdl/plb_ddr2_pkg.sv */
package plb_ddr2_pkg;

   //----------------------------------------------------------------------
   // Memory window and sizes
   //----------------------------------------------------------------------

   localparam logic [31:0] MEM_BASE_ADDR = 32'h0000_0000;
   localparam logic [31:0] MEM_HIGH_ADDR = 32'h0000_0FFF;

   // 256 lines of 16 bytes
   localparam int LINE_AW     = 8;
   localparam int MEM_LINES   = 1 << LINE_AW;

   localparam int DWORD_W     = 64;
   localparam int DWORD_BYTES = DWORD_W / 8;
   localparam int LINE_W      = 2 * DWORD_W;
   localparam int LINE_BYTES  = LINE_W / 8;

   // Accepted PLB_size codes
   localparam logic [3:0] SIZE_SINGLE = 4'd0;
   localparam logic [3:0] SIZE_LINE   = 4'd1;

   // Read strobe to valid strobe, in cycles
   localparam int READ_LATENCY = 2;

   //----------------------------------------------------------------------
   // Bus request and memory command
   //----------------------------------------------------------------------

   typedef struct packed {
      logic [31:0]            addr;
      logic                   rnw;
      logic [DWORD_BYTES-1:0] be;
      logic [3:0]             size;
   } plb_req_t;

   // One memory line, whole or split by address bit 3
   typedef union packed {
      logic [LINE_W-1:0]           raw;
      logic [1:0][DWORD_W-1:0]     dword;
   } mem_line_u;

   typedef struct packed {
      logic                  rd;
      logic                  wr;
      logic [LINE_AW-1:0]    line_addr;
      // Bit 8k+i is byte i of doubleword k
      logic [LINE_BYTES-1:0] be;
      mem_line_u             wdata;
   } ddr_cmd_t;

endpackage

/* hdl/plb_slave_fsm.sv */
`timescale 1ns/1ps

module plb_slave_fsm (
   input  logic                                   plb_clk,
   input  logic                                   rst,
   input  logic                                   pa_valid,
   input  plb_ddr2_pkg::plb_req_t                 req,
   input  logic [1:0]                             beat,
   input  logic                                   last,
   input  logic                                   line_done,
   input  logic                                   rd_valid,
   output logic                                   cnt_clear,
   output logic                                   cnt_advance,
   output logic                                   wr_capture,
   output logic                                   rd_select,
   output logic                                   single,
   output logic                                   addr_bit3,
   output logic [plb_ddr2_pkg::DWORD_BYTES-1:0]   byte_en,
   output logic                                   cmd_rd,
   output logic                                   cmd_wr,
   output logic [plb_ddr2_pkg::LINE_AW-1:0]       line_addr,
   output logic                                   addr_ack,
   output logic                                   wr_dack,
   output logic                                   wr_comp,
   output logic                                   rd_dack,
   output logic                                   rd_comp,
   output logic [1:0]                             rd_wd_addr
);

   import plb_ddr2_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_WR_BEATS,
      ST_RD_WAIT,
      ST_RD_BEATS
   } state_t;

   state_t      state;
   logic        rd_second;
   logic [31:0] req_off;
   logic        req_single;
   logic        req_ok;
   logic        accept;
   logic        xfer_last;

   //----------------------------------------------------------------------
   // Request decode, only looked at while idle
   //----------------------------------------------------------------------

   // Addresses below the base wrap to a large offset and fall outside
   assign req_off    = req.addr - MEM_BASE_ADDR;
   assign req_single = (req.size == SIZE_SINGLE);
   assign req_ok     = (req_off <= (MEM_HIGH_ADDR - MEM_BASE_ADDR)) &&
                       (req_single || (req.size == SIZE_LINE));
   assign accept     = (state == ST_IDLE) && pa_valid && req_ok;

   // Single transfers end on their only beat
   assign xfer_last  = single || last;

   assign cnt_clear   = accept;
   assign cnt_advance = wr_dack || rd_dack;
   assign wr_capture  = wr_dack;
   assign rd_select   = rd_dack;
   assign rd_wd_addr  = rd_dack ? beat : 2'd0;

   // Transfer attributes, held for the open transfer
   always_ff @(posedge plb_clk) begin
      if (accept) begin
         single    <= req_single;
         addr_bit3 <= req.addr[3];
         byte_en   <= req.be;
         line_addr <= req_off[LINE_AW+3:4];
      end else if ((cmd_wr || cmd_rd) && !single) begin
         // Step to the second line of a line transfer
         line_addr <= line_addr + LINE_AW'(1);
      end
   end

   //----------------------------------------------------------------------
   // Control FSM
   //----------------------------------------------------------------------

   always_ff @(posedge plb_clk) begin
      if (rst) begin
         state     <= ST_IDLE;
         rd_second <= 1'b0;
         addr_ack  <= 1'b0;
         wr_dack   <= 1'b0;
         wr_comp   <= 1'b0;
         rd_dack   <= 1'b0;
         rd_comp   <= 1'b0;
         cmd_rd    <= 1'b0;
         cmd_wr    <= 1'b0;
      end else begin
         addr_ack <= accept;
         cmd_rd   <= 1'b0;
         // Line is complete after an odd beat, or after a single beat
         cmd_wr   <= wr_dack && (single || line_done);

         case (state)
            ST_IDLE: begin
               if (accept) begin
                  rd_second <= 1'b0;
                  if (req.rnw) begin
                     cmd_rd <= 1'b1;
                     state  <= ST_RD_WAIT;
                  end else begin
                     wr_dack <= 1'b1;
                     wr_comp <= req_single;
                     state   <= ST_WR_BEATS;
                  end
               end
            end

            ST_WR_BEATS: begin
               if (xfer_last) begin
                  wr_dack <= 1'b0;
                  wr_comp <= 1'b0;
                  state   <= ST_IDLE;
               end else begin
                  wr_comp <= (beat == 2'd2);
               end
            end

            ST_RD_WAIT: begin
               if (rd_valid) begin
                  rd_dack <= 1'b1;
                  rd_comp <= single;
                  state   <= ST_RD_BEATS;
                  // Second line fetch goes out right behind the first
                  if (!single && !rd_second) begin
                     cmd_rd    <= 1'b1;
                     rd_second <= 1'b1;
                  end
               end
            end

            ST_RD_BEATS: begin
               if (xfer_last) begin
                  rd_dack <= 1'b0;
                  rd_comp <= 1'b0;
                  state   <= ST_IDLE;
               end else if (line_done) begin
                  rd_dack <= 1'b0;
                  state   <= ST_RD_WAIT;
               end else begin
                  rd_comp <= (beat == 2'd2);
               end
            end

            default: state <= ST_IDLE;
         endcase
      end
   end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and decide pass or fail from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f compile.f --top-module plb_ddr2_tb \
   && ./obj_dir/Vplb_ddr2_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^PASS: all tests$" sim.log \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }
